// File: sources.f
logic/qpu_pkg.sv
logic/qpu_exu_decode.sv
logic/qpu_exu_disp.sv
logic/qpu_exu_oitf.sv
logic/qpu_exu_alu.sv
logic/qpu_exu_regfile.sv
logic/qpu_exu.sv
dv/tb_clk_gen.sv
dv/tb_qpu_exu.sv

// File: Bender.yml
package:
  name: qpu_exu

sources:
  - logic/qpu_pkg.sv
  - logic/qpu_exu_decode.sv
  - logic/qpu_exu_disp.sv
  - logic/qpu_exu_oitf.sv
  - logic/qpu_exu_alu.sv
  - logic/qpu_exu_regfile.sv
  - logic/qpu_exu.sv
  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_qpu_exu.sv

// File: dv/tb_qpu_exu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_qpu_exu import qpu_pkg::*;
();

  localparam int OITF_DEPTH     = 4;
  localparam int ACCEPT_TIMEOUT = 200;
  localparam int DRAIN_TIMEOUT  = 200;
  localparam int NUM_RANDOM     = 400;

  logic    clk;
  logic    arst_n;
  logic    i_instr_valid;
  logic    o_instr_ready;
  instr_t  i_instr;
  logic    o_tiq_valid;
  logic    i_tiq_ready;
  time_t   o_tiq_time;
  logic    o_evq_valid;
  logic    i_evq_ready;
  time_t   o_evq_time;
  qubits_t o_evq_qubits;
  logic    i_mcu_valid;
  qubits_t i_mcu_result;
  logic    o_wb_valid;
  rfidx_t  o_wb_rdidx;
  data_t   o_wb_data;

  // Reference model state
  data_t   m_regs [RF_NUM];
  time_t   m_time;
  qubits_t m_meas;
  qubits_t pend_q [$];
  logic    m_tiq_valid;
  time_t   m_tiq_time;
  logic    m_evq_valid;
  time_t   m_evq_time;
  qubits_t m_evq_qubits;
  logic    m_wb_valid;
  rfidx_t  m_wb_rdidx;
  data_t   m_wb_data;
  logic    exp_ready;

  int      errors;
  int      timeouts;
  int      full_stalls;
  int      fmr_stalls;
  int      tiq_items;
  logic    rand_ready_en;
  logic    mcu_en;
  int      mcu_delay;

  tb_clk_gen #(
    .PERIOD       (8),
    .RESET_CYCLES (2)
  ) u_clk_gen (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  qpu_exu #(
    .OITF_DEPTH (OITF_DEPTH)
  ) uut (
    .clk           (clk),
    .i_arst_n      (arst_n),
    .i_instr_valid (i_instr_valid),
    .o_instr_ready (o_instr_ready),
    .i_instr       (i_instr),
    .o_tiq_valid   (o_tiq_valid),
    .i_tiq_ready   (i_tiq_ready),
    .o_tiq_time    (o_tiq_time),
    .o_evq_valid   (o_evq_valid),
    .i_evq_ready   (i_evq_ready),
    .o_evq_time    (o_evq_time),
    .o_evq_qubits  (o_evq_qubits),
    .i_mcu_valid   (i_mcu_valid),
    .i_mcu_result  (i_mcu_result),
    .o_wb_valid    (o_wb_valid),
    .o_wb_rdidx    (o_wb_rdidx),
    .o_wb_data     (o_wb_data)
  );

  ////////////////////////////////////////
  // Instruction helpers
  ////////////////////////////////////////
  function automatic instr_t make_instr(input logic [3:0] op, input rfidx_t rd,
                                        input rfidx_t rs1, input rfidx_t rs2,
                                        input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  function automatic instr_t rand_instr();
    int          kind;
    logic [3:0]  op;
    logic [15:0] imm;
    kind = $urandom_range(0, 6);
    case (kind)
      0:
      begin
        op  = OP_NOP;
        imm = 16'($urandom_range(0, 255));
      end
      1:
      begin
        op  = OP_ADD;
        imm = 16'd0;
      end
      2:
      begin
        op  = OP_ADDI;
        imm = 16'($urandom_range(0, 64)) - 16'd32;
      end
      3:
      begin
        op  = OP_QWAIT;
        imm = 16'($urandom_range(0, 40));
      end
      4:
      begin
        op  = OP_MEASURE;
        imm = 16'($urandom_range(1, 255));
      end
      5:
      begin
        op  = OP_FMR;
        imm = 16'($urandom_range(0, 7));
      end
      // Undefined opcodes behave as NOP
      default:
      begin
        op  = 4'($urandom_range(6, 15));
        imm = 16'($urandom);
      end
    endcase
    return make_instr(op, rfidx_t'($urandom_range(0, 15)), rfidx_t'($urandom_range(0, 15)),
                      rfidx_t'($urandom_range(0, 15)), imm);
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////
  function automatic logic ref_ready(input instr_t instr, input logic tiq_rdy,
                                     input logic evq_rdy);
    qubits_t pend_mask;
    pend_mask = '0;
    foreach (pend_q[i])
      pend_mask = pend_mask | pend_q[i];
    case (instr[31:28])
      OP_FMR:     return !pend_mask[instr[2:0]];
      OP_MEASURE: return (pend_q.size() < OITF_DEPTH) && !(m_evq_valid && !evq_rdy);
      OP_QWAIT:   return !(m_tiq_valid && !tiq_rdy);
      default:    return 1'b1;
    endcase
  endfunction

  // Advances the model across one rising edge
  function automatic void ref_step(input logic accept, input instr_t instr,
                                   input logic tiq_rdy, input logic evq_rdy,
                                   input logic mcu_vld, input qubits_t mcu_res);
    logic [3:0] op;
    rfidx_t     rd;
    data_t      a;
    data_t      b;
    data_t      result;
    qubits_t    head;
    op = accept ? instr[31:28] : 4'(OP_NOP);
    rd = instr[27:24];
    a  = m_regs[instr[23:20]];
    b  = m_regs[instr[19:16]];
    m_wb_valid = 1'b0;
    if (op == OP_ADD || op == OP_ADDI || op == OP_FMR)
    begin
      if (op == OP_ADD)
        result = a + b;
      else if (op == OP_ADDI)
        result = a + {{16{instr[15]}}, instr[15:0]};
      else
        result = data_t'(m_meas[instr[2:0]]);
      if (rd != '0)
        m_regs[rd] = result;
      m_wb_valid = 1'b1;
      m_wb_rdidx = rd;
      m_wb_data  = result;
    end
    if (op == OP_QWAIT)
    begin
      m_time      = m_time + time_t'(instr[15:0]);
      m_tiq_valid = 1'b1;
      m_tiq_time  = m_time;
    end
    else if (tiq_rdy)
      m_tiq_valid = 1'b0;
    if (op == OP_MEASURE)
    begin
      m_evq_valid  = 1'b1;
      m_evq_time   = m_time;
      m_evq_qubits = instr[7:0];
    end
    else if (evq_rdy)
      m_evq_valid = 1'b0;
    // Return answers the oldest measure
    if (mcu_vld && pend_q.size() > 0)
    begin
      head   = pend_q.pop_front();
      m_meas = (m_meas & ~head) | (mcu_res & head);
    end
    if (op == OP_MEASURE)
      pend_q.push_back(instr[7:0]);
  endfunction

  task automatic log_mismatch(input string name, input data_t got, input data_t exp);
    errors++;
    $display("Mismatch %s: got %h expected %h at %0t", name, got, exp, $time);
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      exp_ready = ref_ready(i_instr, i_tiq_ready, i_evq_ready);
      assert (o_instr_ready == exp_ready)
      else log_mismatch("o_instr_ready", data_t'(o_instr_ready), data_t'(exp_ready));
      assert (o_tiq_valid == m_tiq_valid)
      else log_mismatch("o_tiq_valid", data_t'(o_tiq_valid), data_t'(m_tiq_valid));
      if (m_tiq_valid)
        assert (o_tiq_time == m_tiq_time)
        else log_mismatch("o_tiq_time", data_t'(o_tiq_time), data_t'(m_tiq_time));
      assert (o_evq_valid == m_evq_valid)
      else log_mismatch("o_evq_valid", data_t'(o_evq_valid), data_t'(m_evq_valid));
      if (m_evq_valid)
      begin
        assert (o_evq_time == m_evq_time)
        else log_mismatch("o_evq_time", data_t'(o_evq_time), data_t'(m_evq_time));
        assert (o_evq_qubits == m_evq_qubits)
        else log_mismatch("o_evq_qubits", data_t'(o_evq_qubits), data_t'(m_evq_qubits));
      end
      assert (o_wb_valid == m_wb_valid)
      else log_mismatch("o_wb_valid", data_t'(o_wb_valid), data_t'(m_wb_valid));
      if (m_wb_valid)
      begin
        assert (o_wb_rdidx == m_wb_rdidx)
        else log_mismatch("o_wb_rdidx", data_t'(o_wb_rdidx), data_t'(m_wb_rdidx));
        assert (o_wb_data == m_wb_data)
        else log_mismatch("o_wb_data", o_wb_data, m_wb_data);
      end
      if (i_instr_valid && i_instr[31:28] == OP_MEASURE && pend_q.size() == OITF_DEPTH
          && !o_instr_ready)
        full_stalls++;
      if (i_instr_valid && i_instr[31:28] == OP_FMR && !o_instr_ready)
        fmr_stalls++;
      if (o_tiq_valid && i_tiq_ready)
        tiq_items++;
      ref_step(i_instr_valid && o_instr_ready, i_instr, i_tiq_ready, i_evq_ready,
               i_mcu_valid, i_mcu_result);
    end
  end

  ////////////////////////////////////////
  // Queue readiness and measurement unit
  ////////////////////////////////////////
  always @(posedge clk)
  begin
    if (rand_ready_en)
    begin
      i_tiq_ready <= 1'($urandom_range(0, 1));
      i_evq_ready <= 1'($urandom_range(0, 1));
    end
    else
    begin
      i_tiq_ready <= 1'b1;
      i_evq_ready <= 1'b1;
    end
    if (mcu_delay > 0)
    begin
      mcu_delay--;
      i_mcu_valid <= 1'b0;
    end
    else if (mcu_en && pend_q.size() > 0)
    begin
      i_mcu_valid  <= 1'b1;
      i_mcu_result <= qubits_t'($urandom_range(0, 255));
      mcu_delay = $urandom_range(0, 6);
    end
    else
      i_mcu_valid <= 1'b0;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////
  task automatic send_instr(input instr_t instr);
    int   cycles;
    logic accepted;
    i_instr_valid <= 1'b1;
    i_instr       <= instr;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < ACCEPT_TIMEOUT)
    begin
      @(negedge clk);
      accepted = o_instr_ready;
      @(posedge clk);
      cycles++;
    end
    i_instr_valid <= 1'b0;
    if (!accepted)
    begin
      timeouts++;
      $display("Timeout: instruction %h was not accepted in %0d cycles", instr, cycles);
    end
  endtask

  // Offers a word for a fixed time, then withdraws it
  task automatic offer_instr(input instr_t instr, input int cycles);
    i_instr_valid <= 1'b1;
    i_instr       <= instr;
    repeat (cycles) @(posedge clk);
    i_instr_valid <= 1'b0;
  endtask

  initial
  begin
    int cycles;
    void'($urandom(76));
    i_instr_valid = 1'b0;
    i_instr       = '0;
    i_tiq_ready   = 1'b1;
    i_evq_ready   = 1'b1;
    i_mcu_valid   = 1'b0;
    i_mcu_result  = '0;
    rand_ready_en = 1'b0;
    mcu_en        = 1'b0;
    mcu_delay     = 0;
    errors        = 0;
    timeouts      = 0;
    full_stalls   = 0;
    fmr_stalls    = 0;
    tiq_items     = 0;
    for (int i = 0; i < RF_NUM; i++)
      m_regs[i] = '0;
    m_time      = '0;
    m_meas      = '0;
    m_tiq_valid = 1'b0;
    m_evq_valid = 1'b0;
    m_wb_valid  = 1'b0;

    cycles = 0;
    while (arst_n !== 1'b1 && cycles < 20)
    begin
      @(posedge clk);
      cycles++;
    end
    if (arst_n !== 1'b1)
    begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    @(posedge clk);

    // First ADD of r0 and r0
    send_instr(make_instr(OP_ADD, 4'd1, 4'd0, 4'd0, 16'd0));

    // Fill the queue with returns held back
    send_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h0005));
    send_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h0030));
    send_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h0081));
    send_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h000c));
    offer_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h0042), 6);
    offer_instr(make_instr(OP_FMR, 4'd2, 4'd0, 4'd0, 16'd0), 4);
    mcu_en = 1'b1;
    send_instr(make_instr(OP_FMR, 4'd2, 4'd0, 4'd0, 16'd0));
    send_instr(make_instr(OP_MEASURE, 4'd0, 4'd0, 4'd0, 16'h0042));

    // Random mix with random back-pressure
    rand_ready_en = 1'b1;
    for (int n = 0; n < NUM_RANDOM; n++)
    begin
      send_instr(rand_instr());
      if ($urandom_range(0, 3) == 0)
        @(posedge clk);
    end

    // Drain outstanding measures and queue slots
    rand_ready_en = 1'b0;
    cycles = 0;
    while ((pend_q.size() != 0 || o_tiq_valid || o_evq_valid) && cycles < DRAIN_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (pend_q.size() != 0 || o_tiq_valid || o_evq_valid)
    begin
      timeouts++;
      $display("Timeout: outstanding work did not drain");
    end
    repeat (3) @(posedge clk);

    assert (full_stalls > 0)
    else
    begin
      errors++;
      $display("A MEASURE was never held back by a full queue");
    end
    assert (fmr_stalls > 0)
    else
    begin
      errors++;
      $display("An FMR was never held back by a pending qubit");
    end
    assert (tiq_items > 0)
    else
    begin
      errors++;
      $display("No timing queue item was ever transferred");
    end

    $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
#(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 2
)
(
  output logic o_clk,
  output logic o_arst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #(PERIOD / 2) o_clk = ~o_clk;
  end

  // Reset held low for a fixed number of rising edges
  initial
  begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    o_arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/qpu_exu.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu import qpu_pkg::*;
#(
  parameter int OITF_DEPTH = 4
)
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_instr_valid,
  output logic    o_instr_ready,
  input  instr_t  i_instr,
  output logic    o_tiq_valid,
  input  logic    i_tiq_ready,
  output time_t   o_tiq_time,
  output logic    o_evq_valid,
  input  logic    i_evq_ready,
  output time_t   o_evq_time,
  output qubits_t o_evq_qubits,
  input  logic    i_mcu_valid,
  input  qubits_t i_mcu_result,
  output logic    o_wb_valid,
  output rfidx_t  o_wb_rdidx,
  output data_t   o_wb_data
);

  opcode_e dec_opcode;
  rfidx_t  dec_rd;
  rfidx_t  dec_rs1;
  rfidx_t  dec_rs2;
  data_t   dec_imm_sext;
  qubits_t dec_qubits;
  qubits_t dec_fmr_qubit_sel;
  logic    dec_rdwen;

  logic    issue;
  logic    oitf_push;
  logic    oitf_full;
  qubits_t oitf_pending;
  qubits_t oitf_head_qubits;

  data_t   rs1_data;
  data_t   rs2_data;
  time_t   cur_time;
  qubits_t meas;
  logic    rf_wen;
  data_t   rf_wdata;
  logic    time_wen;
  time_t   time_next;
  logic    tiq_free;
  logic    evq_free;

  // Every issued MEASURE takes a queue entry
  assign oitf_push = issue && (dec_opcode == OP_MEASURE);

  qpu_exu_decode u_decode (
    .i_instr         (i_instr),
    .o_opcode        (dec_opcode),
    .o_rd            (dec_rd),
    .o_rs1           (dec_rs1),
    .o_rs2           (dec_rs2),
    .o_imm_sext      (dec_imm_sext),
    .o_qubits        (dec_qubits),
    .o_fmr_qubit_sel (dec_fmr_qubit_sel),
    .o_rdwen         (dec_rdwen)
  );

  qpu_exu_disp u_disp (
    .i_instr_valid   (i_instr_valid),
    .o_instr_ready   (o_instr_ready),
    .i_opcode        (dec_opcode),
    .i_fmr_qubit_sel (dec_fmr_qubit_sel),
    .i_pending       (oitf_pending),
    .i_oitf_full     (oitf_full),
    .i_tiq_free      (tiq_free),
    .i_evq_free      (evq_free),
    .o_issue         (issue)
  );

  qpu_exu_oitf #(
    .OITF_DEPTH (OITF_DEPTH)
  ) u_oitf (
    .clk           (clk),
    .i_arst_n      (i_arst_n),
    .i_push        (oitf_push),
    .i_push_qubits (dec_qubits),
    .i_pop         (i_mcu_valid),
    .o_full        (oitf_full),
    .o_pending     (oitf_pending),
    .o_head_qubits (oitf_head_qubits)
  );

  qpu_exu_alu u_alu (
    .clk             (clk),
    .i_arst_n        (i_arst_n),
    .i_issue         (issue),
    .i_opcode        (dec_opcode),
    .i_rd            (dec_rd),
    .i_rdwen         (dec_rdwen),
    .i_rs1_data      (rs1_data),
    .i_rs2_data      (rs2_data),
    .i_imm_sext      (dec_imm_sext),
    .i_qubits        (dec_qubits),
    .i_fmr_qubit_sel (dec_fmr_qubit_sel),
    .i_time          (cur_time),
    .i_meas          (meas),
    .o_rf_wen        (rf_wen),
    .o_rf_wdata      (rf_wdata),
    .o_time_wen      (time_wen),
    .o_time_next     (time_next),
    .i_tiq_ready     (i_tiq_ready),
    .i_evq_ready     (i_evq_ready),
    .o_tiq_free      (tiq_free),
    .o_evq_free      (evq_free),
    .o_tiq_valid     (o_tiq_valid),
    .o_tiq_time      (o_tiq_time),
    .o_evq_valid     (o_evq_valid),
    .o_evq_time      (o_evq_time),
    .o_evq_qubits    (o_evq_qubits),
    .o_wb_valid      (o_wb_valid),
    .o_wb_rdidx      (o_wb_rdidx),
    .o_wb_data       (o_wb_data)
  );

  qpu_exu_regfile u_regfile (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_rs1        (dec_rs1),
    .i_rs2        (dec_rs2),
    .i_wen        (rf_wen),
    .i_wdst       (dec_rd),
    .i_wdata      (rf_wdata),
    .i_time_wen   (time_wen),
    .i_time_next  (time_next),
    .i_mcu_valid  (i_mcu_valid),
    .i_mcu_result (i_mcu_result),
    .i_mcu_qubits (oitf_head_qubits),
    .o_rs1_data   (rs1_data),
    .o_rs2_data   (rs2_data),
    .o_time       (cur_time),
    .o_meas       (meas)
  );

endmodule

`default_nettype wire

// File: logic/qpu_exu_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu_regfile import qpu_pkg::*;
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  rfidx_t  i_rs1,
  input  rfidx_t  i_rs2,
  input  logic    i_wen,
  input  rfidx_t  i_wdst,
  input  data_t   i_wdata,
  input  logic    i_time_wen,
  input  time_t   i_time_next,
  input  logic    i_mcu_valid,
  input  qubits_t i_mcu_result,
  input  qubits_t i_mcu_qubits,
  output data_t   o_rs1_data,
  output data_t   o_rs2_data,
  output time_t   o_time,
  output qubits_t o_meas
);

  // r0 has no storage
  data_t regs [1:RF_NUM-1];

  ////////////////////////////////////////
  // Classical registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      for (int i = 1; i < RF_NUM; i++)
        regs[i] <= '0;
    end
    else if (i_wen && (i_wdst != '0))
    begin
      regs[i_wdst] <= i_wdata;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

  ////////////////////////////////////////
  // Time and measurement registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_time <= '0;
      o_meas <= '0;
    end
    else
    begin
      if (i_time_wen)
        o_time <= i_time_next;
      // Only the returning measure's qubits change
      if (i_mcu_valid)
        o_meas <= (o_meas & ~i_mcu_qubits) | (i_mcu_result & i_mcu_qubits);
    end
  end

endmodule

`default_nettype wire

// File: logic/qpu_exu_alu.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu_alu import qpu_pkg::*;
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_issue,
  input  opcode_e i_opcode,
  input  rfidx_t  i_rd,
  input  logic    i_rdwen,
  input  data_t   i_rs1_data,
  input  data_t   i_rs2_data,
  input  data_t   i_imm_sext,
  input  qubits_t i_qubits,
  input  qubits_t i_fmr_qubit_sel,
  input  time_t   i_time,
  input  qubits_t i_meas,
  output logic    o_rf_wen,
  output data_t   o_rf_wdata,
  output logic    o_time_wen,
  output time_t   o_time_next,
  input  logic    i_tiq_ready,
  input  logic    i_evq_ready,
  output logic    o_tiq_free,
  output logic    o_evq_free,
  output logic    o_tiq_valid,
  output time_t   o_tiq_time,
  output logic    o_evq_valid,
  output time_t   o_evq_time,
  output qubits_t o_evq_qubits,
  output logic    o_wb_valid,
  output rfidx_t  o_wb_rdidx,
  output data_t   o_wb_data
);

  data_t op2;
  logic  fmr_bit;
  logic  issue_qwait;
  logic  issue_measure;
  logic  issue_wb;

  ////////////////////////////////////////
  // Execute
  ////////////////////////////////////////
  assign op2     = (i_opcode == OP_ADDI) ? i_imm_sext : i_rs2_data;
  assign fmr_bit = |(i_meas & i_fmr_qubit_sel);

  assign o_rf_wdata = (i_opcode == OP_FMR) ? data_t'(fmr_bit) : i_rs1_data + op2;
  assign o_rf_wen   = i_issue && i_rdwen;

  // QWAIT immediate is zero-extended
  assign o_time_next = i_time + time_t'(i_imm_sext[IMM_WIDTH-1:0]);

  assign issue_qwait   = i_issue && (i_opcode == OP_QWAIT);
  assign issue_measure = i_issue && (i_opcode == OP_MEASURE);
  assign issue_wb      = i_issue && i_rdwen;
  assign o_time_wen    = issue_qwait;

  // Slot can take a new item this cycle
  assign o_tiq_free = !o_tiq_valid || i_tiq_ready;
  assign o_evq_free = !o_evq_valid || i_evq_ready;

  ////////////////////////////////////////
  // Output registers
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      o_tiq_valid <= 1'b0;
      o_evq_valid <= 1'b0;
      o_wb_valid  <= 1'b0;
    end
    else
    begin
      if (issue_qwait)
        o_tiq_valid <= 1'b1;
      else if (i_tiq_ready)
        o_tiq_valid <= 1'b0;
      if (issue_measure)
        o_evq_valid <= 1'b1;
      else if (i_evq_ready)
        o_evq_valid <= 1'b0;
      // Trace lasts one cycle
      o_wb_valid <= issue_wb;
    end
  end

  always_ff @(posedge clk)
  begin
    if (issue_qwait)
      o_tiq_time <= o_time_next;
    if (issue_measure)
    begin
      o_evq_time   <= i_time;
      o_evq_qubits <= i_qubits;
    end
    if (issue_wb)
    begin
      o_wb_rdidx <= i_rd;
      o_wb_data  <= o_rf_wdata;
    end
  end

  a_tiq_hold : assert property (@(posedge clk) disable iff (!i_arst_n)
    (o_tiq_valid && !i_tiq_ready) |=> (o_tiq_valid && $stable(o_tiq_time)));

endmodule

`default_nettype wire

// File: logic/qpu_exu_oitf.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu_oitf import qpu_pkg::*;
#(
  parameter int OITF_DEPTH = 4
)
(
  input  logic    clk,
  input  logic    i_arst_n,
  input  logic    i_push,
  input  qubits_t i_push_qubits,
  input  logic    i_pop,
  output logic    o_full,
  output qubits_t o_pending,
  output qubits_t o_head_qubits
);

  localparam int PTR_WIDTH = $clog2(OITF_DEPTH);
  localparam int CNT_WIDTH = $clog2(OITF_DEPTH + 1);

  qubits_t                mem [OITF_DEPTH];
  logic [OITF_DEPTH-1:0]  vld;
  logic [PTR_WIDTH-1:0]   wr_ptr;
  logic [PTR_WIDTH-1:0]   rd_ptr;
  logic [CNT_WIDTH-1:0]   count;

  if (OITF_DEPTH < 2)
  begin : g_depth_check
    $error("OITF_DEPTH must be at least 2");
  end

  ////////////////////////////////////////
  // Pointers, count and entry valid bits
  ////////////////////////////////////////
  always_ff @(posedge clk or negedge i_arst_n)
  begin
    if (!i_arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      vld    <= '0;
    end
    else
    begin
      if (i_push)
      begin
        vld[wr_ptr] <= 1'b1;
        wr_ptr <= (wr_ptr == PTR_WIDTH'(OITF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop)
      begin
        vld[rd_ptr] <= 1'b0;
        rd_ptr <= (rd_ptr == PTR_WIDTH'(OITF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (i_push && !i_pop)
        count <= count + 1'b1;
      else if (i_pop && !i_push)
        count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (i_push)
      mem[wr_ptr] <= i_push_qubits;
  end

  assign o_full        = (count == CNT_WIDTH'(OITF_DEPTH));
  assign o_head_qubits = mem[rd_ptr];

  // OR of every outstanding mask
  always_comb
  begin
    o_pending = '0;
    for (int i = 0; i < OITF_DEPTH; i++)
    begin
      if (vld[i])
        o_pending = o_pending | mem[i];
    end
  end

  a_no_push_full : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_push |-> !o_full);

  a_no_pop_empty : assert property (@(posedge clk) disable iff (!i_arst_n)
    i_pop |-> (count != '0));

endmodule

`default_nettype wire

// File: logic/qpu_exu_disp.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu_disp import qpu_pkg::*;
(
  input  logic    i_instr_valid,
  output logic    o_instr_ready,
  input  opcode_e i_opcode,
  input  qubits_t i_fmr_qubit_sel,
  input  qubits_t i_pending,
  input  logic    i_oitf_full,
  input  logic    i_tiq_free,
  input  logic    i_evq_free,
  output logic    o_issue
);

  logic fmr_stall;
  logic measure_stall;
  logic qwait_stall;

  ////////////////////////////////////////
  // Stall conditions per opcode
  ////////////////////////////////////////

  // Result bit still on its way back
  assign fmr_stall = (i_opcode == OP_FMR) && |(i_fmr_qubit_sel & i_pending);

  // Needs a queue entry and an empty event slot
  assign measure_stall = (i_opcode == OP_MEASURE) && (i_oitf_full || !i_evq_free);

  assign qwait_stall = (i_opcode == OP_QWAIT) && !i_tiq_free;

  // Ready only looks at the offered word and current state
  assign o_instr_ready = !(fmr_stall || measure_stall || qwait_stall);

  assign o_issue = i_instr_valid && o_instr_ready;

endmodule

`default_nettype wire

// File: logic/qpu_exu_decode.sv
`timescale 1ns/1ns
`default_nettype none

module qpu_exu_decode import qpu_pkg::*;
(
  input  instr_t  i_instr,
  output opcode_e o_opcode,
  output rfidx_t  o_rd,
  output rfidx_t  o_rs1,
  output rfidx_t  o_rs2,
  output data_t   o_imm_sext,
  output qubits_t o_qubits,
  output qubits_t o_fmr_qubit_sel,
  output logic    o_rdwen
);

  logic [IMM_WIDTH-1:0] imm;

  assign imm   = i_instr[IMM_WIDTH-1:0];
  assign o_rd  = i_instr[27:24];
  assign o_rs1 = i_instr[23:20];
  assign o_rs2 = i_instr[19:16];

  // Unknown opcodes fall back to NOP
  always_comb
  begin
    case (i_instr[31:28])
      OP_ADD:     o_opcode = OP_ADD;
      OP_ADDI:    o_opcode = OP_ADDI;
      OP_QWAIT:   o_opcode = OP_QWAIT;
      OP_MEASURE: o_opcode = OP_MEASURE;
      OP_FMR:     o_opcode = OP_FMR;
      default:    o_opcode = OP_NOP;
    endcase
  end

  assign o_imm_sext = {{(XLEN-IMM_WIDTH){imm[IMM_WIDTH-1]}}, imm};

  // Qubit mask sits in the low immediate byte
  assign o_qubits = imm[QUBIT_NUM-1:0];

  // FMR picks one qubit by number
  assign o_fmr_qubit_sel = qubits_t'(1) << imm[$clog2(QUBIT_NUM)-1:0];

  assign o_rdwen = (o_opcode == OP_ADD) || (o_opcode == OP_ADDI) || (o_opcode == OP_FMR);

endmodule

`default_nettype wire

// File: logic/qpu_pkg.sv
`default_nettype none

package qpu_pkg;

  ////////////////////////////////////////
  // Widths fixed by the instruction format
  ////////////////////////////////////////
  localparam int XLEN        = 32;
  localparam int INSTR_WIDTH = 32;
  localparam int RFIDX_WIDTH = 4;
  localparam int IMM_WIDTH   = 16;
  localparam int TIME_WIDTH  = 20;
  localparam int QUBIT_NUM   = 8;

  // Number of classical registers, r0 included
  localparam int RF_NUM = 2 ** RFIDX_WIDTH;

  typedef logic [INSTR_WIDTH-1:0] instr_t;
  typedef logic [XLEN-1:0]        data_t;
  typedef logic [RFIDX_WIDTH-1:0] rfidx_t;
  typedef logic [TIME_WIDTH-1:0]  time_t;
  typedef logic [QUBIT_NUM-1:0]   qubits_t;

  ////////////////////////////////////////
  // Opcodes in bits 31..28 of the word
  ////////////////////////////////////////
  typedef enum logic [3:0] {
    OP_NOP     = 4'd0,
    OP_ADD     = 4'd1,
    OP_ADDI    = 4'd2,
    OP_QWAIT   = 4'd3,
    OP_MEASURE = 4'd4,
    OP_FMR     = 4'd5
  } opcode_e;

endpackage

`default_nettype wire
